//--- files.f
hdl/cpu_pkg.sv
hdl/prog_ram.sv
hdl/mem_arbiter.sv
hdl/prog_loader.sv
hdl/cpu_core.sv
hdl/cpu_subsystem.sv
test/tb_clock_gen.sv
test/arb_checker.sv
test/cpu_tb.sv

//--- hdl/cpu_core.sv
/* Accumulator-style CPU core: fetches over a four-phase memory handshake and
   executes one instruction per fetch. Started and restarted by the loader. */
`timescale 1ns/1ns

module cpu_core (
    input  logic               clk,
    input  logic               pon_rst_n_i,
    input  logic               start_i,
    input  cpu_pkg::addr_t     start_addr_i,
    input  logic               mem_ack_i,
    input  cpu_pkg::word_t     mem_rdata_i,
    output logic               mem_req_o,
    output cpu_pkg::mem_req_t  mem_o,
    output cpu_pkg::addr_t     pc_o,
    output cpu_pkg::word_t     r0_o,
    output logic               halt_o,
    output logic               running_o
);

    cpu_pkg::core_state_t state;
    cpu_pkg::addr_t       pc;
    cpu_pkg::addr_t       pc_inc;
    cpu_pkg::word_t       instr;                          // Latched at fetch ack
    cpu_pkg::word_t       regs [cpu_pkg::NUM_REGS];
    logic                 halt;
    logic                 running;

    // Instruction fields
    cpu_pkg::opcode_t     op;
    cpu_pkg::reg_idx_t    rd;
    cpu_pkg::reg_idx_t    rs;
    cpu_pkg::reg_idx_t    rt;

    assign op = instr[15:12];
    assign rd = instr[11:9];
    assign rs = instr[8:6];
    assign rt = instr[5:3];

    assign pc_inc = pc + 13'd1;                           // Wraps at 13 bits

    // Fetch port, reads only
    assign mem_req_o   = (state == cpu_pkg::FETCH_REQ);
    assign mem_o.we    = 1'b0;
    assign mem_o.addr  = pc;
    assign mem_o.wdata = '0;

    assign pc_o      = pc;
    assign r0_o      = regs[0];
    assign halt_o    = halt;
    assign running_o = running;

    // Control FSM and program counter
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state   <= cpu_pkg::IDLE;
            pc      <= '0;
            halt    <= 1'b0;
            running <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::IDLE,
                cpu_pkg::HALTED: begin
                    // Only a stopped core accepts a start
                    if (start_i) begin
                        pc      <= start_addr_i;
                        halt    <= 1'b0;
                        running <= 1'b1;
                        state   <= cpu_pkg::FETCH_REQ;
                    end
                end
                cpu_pkg::FETCH_REQ: begin
                    if (mem_ack_i) begin
                        state <= cpu_pkg::FETCH_WAIT;     // Req drops here
                    end
                end
                cpu_pkg::FETCH_WAIT: begin
                    if (!mem_ack_i) begin
                        state <= cpu_pkg::EXEC;
                    end
                end
                cpu_pkg::EXEC: begin
                    state <= cpu_pkg::FETCH_REQ;
                    case (op)
                        cpu_pkg::OP_JMP: begin
                            pc <= instr[12:0];
                        end
                        cpu_pkg::OP_HALT: begin
                            halt    <= 1'b1;              // PC stays on the HALT
                            running <= 1'b0;
                            state   <= cpu_pkg::HALTED;
                        end
                        default: begin
                            pc <= pc_inc;
                        end
                    endcase
                end
                default: begin
                    state <= cpu_pkg::IDLE;
                end
            endcase
        end
    end

    // Instruction latch, payload only
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::FETCH_REQ && mem_ack_i) begin
            instr <= mem_rdata_i;
        end
    end

    // Register file writes happen in EXEC
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (state == cpu_pkg::EXEC) begin
            case (op)
                cpu_pkg::OP_ADD: begin
                    regs[rd] <= regs[rs] + regs[rt];      // Modulo 2^16
                end
                cpu_pkg::OP_SUB: begin
                    regs[rd] <= regs[rs] - regs[rt];
                end
                cpu_pkg::OP_LDI: begin
                    regs[rd] <= {8'h00, instr[7:0]};      // Zero-extended byte
                end
                default: ;                                // NOP, JMP, HALT, undefined
            endcase
        end
    end

endmodule

//--- hdl/cpu_pkg.sv
/* Shared widths, opcodes, bus structs and FSM encodings for the CPU subsystem.
   Modules refer to these through scoped names. */
package cpu_pkg;

    typedef logic [12:0] addr_t;    // Program address
    typedef logic [15:0] word_t;    // Instruction or register value
    typedef logic [2:0]  reg_idx_t; // Register number
    typedef logic [3:0]  opcode_t;  // Instruction bits [15:12]

    localparam int NUM_REGS   = 8;
    localparam int PROG_DEPTH = 8192;

    // Opcodes, anything else behaves as NOP
    localparam opcode_t OP_NOP  = 4'h0;
    localparam opcode_t OP_ADD  = 4'h1;
    localparam opcode_t OP_SUB  = 4'h2;
    localparam opcode_t OP_LDI  = 4'h3;
    localparam opcode_t OP_JMP  = 4'h4;
    localparam opcode_t OP_HALT = 4'hf;

    // Host command kinds
    localparam logic CMD_WRITE = 1'b0;
    localparam logic CMD_START = 1'b1;

    typedef struct packed {
        logic  kind;   // CMD_WRITE or CMD_START
        addr_t addr;   // Write address or start address
        word_t data;   // Write data, unused by start
    } host_cmd_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {IDLE, FETCH_REQ, FETCH_WAIT, EXEC, HALTED} core_state_t;

    typedef enum logic [2:0] {L_IDLE, L_WRITE, L_WAIT_DROP, L_START, L_ACK} loader_state_t;

    typedef enum logic [1:0] {A_IDLE, A_READ, A_ACK, A_DROP} arb_state_t;

endpackage

//--- hdl/cpu_subsystem.sv
/* Top level of the CPU subsystem: host loader and core share the program RAM
   through the arbiter. Loader is requester 0, core is requester 1. */
`timescale 1ns/1ns

module cpu_subsystem (
    input  logic                clk,
    input  logic                pon_rst_n_i,
    input  logic                cmd_req_i,
    input  cpu_pkg::host_cmd_t  cmd_i,
    output logic                cmd_ack_o,
    output cpu_pkg::addr_t      pc_o,
    output cpu_pkg::word_t      r0_o,
    output logic                halt_o,
    output logic                running_o
);

    logic [1:0]              arb_req;
    logic [1:0]              arb_ack;
    cpu_pkg::mem_req_t [1:0] arb_mem;
    cpu_pkg::word_t          arb_rdata;
    logic                    ram_en;
    cpu_pkg::mem_req_t       ram_req;
    cpu_pkg::word_t          ram_rdata;
    logic                    start;
    cpu_pkg::addr_t          start_addr;

    prog_loader i_prog_loader (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .cmd_req_i    (cmd_req_i),
        .cmd_i        (cmd_i),
        .mem_ack_i    (arb_ack[0]),
        .cmd_ack_o    (cmd_ack_o),
        .mem_req_o    (arb_req[0]),
        .mem_o        (arb_mem[0]),
        .start_o      (start),
        .start_addr_o (start_addr)
    );

    cpu_core i_cpu_core (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .start_i      (start),
        .start_addr_i (start_addr),
        .mem_ack_i    (arb_ack[1]),
        .mem_rdata_i  (arb_rdata),
        .mem_req_o    (arb_req[1]),
        .mem_o        (arb_mem[1]),
        .pc_o         (pc_o),
        .r0_o         (r0_o),
        .halt_o       (halt_o),
        .running_o    (running_o)
    );

    mem_arbiter i_mem_arbiter (
        .clk          (clk),
        .pon_rst_n_i  (pon_rst_n_i),
        .req_i        (arb_req),
        .mem_i        (arb_mem),
        .ram_rdata_i  (ram_rdata),
        .ack_o        (arb_ack),
        .rdata_o      (arb_rdata),
        .ram_en_o     (ram_en),
        .ram_o        (ram_req)
    );

    prog_ram i_prog_ram (
        .clk          (clk),
        .en_i         (ram_en),
        .req_i        (ram_req),
        .rdata_o      (ram_rdata)
    );

endmodule

//--- hdl/mem_arbiter.sv
/* Round-robin arbiter between the loader (0) and the core (1) on the single
   RAM port. Each requester sees a four-phase req/ack handshake. */
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                     clk,
    input  logic                     pon_rst_n_i,
    input  logic [1:0]               req_i,
    input  cpu_pkg::mem_req_t [1:0]  mem_i,
    input  cpu_pkg::word_t           ram_rdata_i,
    output logic [1:0]               ack_o,
    output cpu_pkg::word_t           rdata_o,
    output logic                     ram_en_o,
    output cpu_pkg::mem_req_t        ram_o
);

    cpu_pkg::arb_state_t state;
    logic                grant;                           // Current or last served
    logic                pick;
    cpu_pkg::word_t      rdata_q;

    // Alternate when both wait, otherwise take whoever asks
    always_comb begin
        if (req_i[0] && req_i[1]) begin
            pick = ~grant;
        end else begin
            pick = req_i[1];
        end
    end

    // RAM access starts in the same cycle the request is taken
    assign ram_en_o = (state == cpu_pkg::A_IDLE) && (req_i != 2'b00);
    assign ram_o    = mem_i[pick];

    assign ack_o   = (state == cpu_pkg::A_ACK) ? (2'b01 << grant) : 2'b00;
    assign rdata_o = rdata_q;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state <= cpu_pkg::A_IDLE;
            grant <= 1'b1;                                // Loader wins first tie
        end else begin
            case (state)
                cpu_pkg::A_IDLE: begin
                    if (req_i != 2'b00) begin
                        grant <= pick;
                        state <= cpu_pkg::A_READ;
                    end
                end
                cpu_pkg::A_READ: state <= cpu_pkg::A_ACK; // RAM data arrives
                cpu_pkg::A_ACK: begin
                    if (!req_i[grant]) state <= cpu_pkg::A_DROP;
                end
                cpu_pkg::A_DROP: state <= cpu_pkg::A_IDLE;
                default:         state <= cpu_pkg::A_IDLE;
            endcase
        end
    end

    // Held for the whole ack phase
    always_ff @(posedge clk) begin
        if (state == cpu_pkg::A_READ) begin
            rdata_q <= ram_rdata_i;
        end
    end

endmodule

//--- hdl/prog_loader.sv
/* Host command sequencer. A write becomes a four-phase RAM write through
   the arbiter, a start becomes a one-cycle start pulse to the core. */
`timescale 1ns/1ns

module prog_loader (
    input  logic                clk,
    input  logic                pon_rst_n_i,
    input  logic                cmd_req_i,
    input  cpu_pkg::host_cmd_t  cmd_i,
    input  logic                mem_ack_i,
    output logic                cmd_ack_o,
    output logic                mem_req_o,
    output cpu_pkg::mem_req_t   mem_o,
    output logic                start_o,
    output cpu_pkg::addr_t      start_addr_o
);

    cpu_pkg::loader_state_t state;
    cpu_pkg::host_cmd_t     cmd_q;                        // Command being served

    assign cmd_ack_o    = (state == cpu_pkg::L_ACK);
    assign mem_req_o    = (state == cpu_pkg::L_WRITE);
    assign start_o      = (state == cpu_pkg::L_START);
    assign start_addr_o = cmd_q.addr;

    assign mem_o.we    = 1'b1;
    assign mem_o.addr  = cmd_q.addr;
    assign mem_o.wdata = cmd_q.data;

    always_ff @(posedge clk) begin
        if (state == cpu_pkg::L_IDLE && cmd_req_i) begin
            cmd_q <= cmd_i;
        end
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state <= cpu_pkg::L_IDLE;
        end else begin
            case (state)
                cpu_pkg::L_IDLE: begin
                    if (cmd_req_i) begin
                        case (cmd_i.kind)
                            cpu_pkg::CMD_WRITE: state <= cpu_pkg::L_WRITE;
                            cpu_pkg::CMD_START: state <= cpu_pkg::L_START;
                            default:            state <= cpu_pkg::L_IDLE;
                        endcase
                    end
                end
                cpu_pkg::L_WRITE: begin
                    if (mem_ack_i) state <= cpu_pkg::L_WAIT_DROP;
                end
                cpu_pkg::L_WAIT_DROP: begin
                    if (!mem_ack_i) state <= cpu_pkg::L_ACK;  // RAM side closed
                end
                cpu_pkg::L_START: state <= cpu_pkg::L_ACK;
                cpu_pkg::L_ACK: begin
                    if (!cmd_req_i) state <= cpu_pkg::L_IDLE;
                end
                default: state <= cpu_pkg::L_IDLE;
            endcase
        end
    end

endmodule

//--- hdl/prog_ram.sv
/* Single-port program memory, written by the loader and read by the core.
   Synchronous write, registered read one cycle after the enable. */
`timescale 1ns/1ns

module prog_ram (
    input  logic               clk,
    input  logic               en_i,
    input  cpu_pkg::mem_req_t  req_i,
    output cpu_pkg::word_t     rdata_o
);

    cpu_pkg::word_t mem [cpu_pkg::PROG_DEPTH];            // Undefined until loaded

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (req_i.we) begin
                mem[req_i.addr] <= req_i.wdata;
            end
            rdata_o <= mem[req_i.addr];                   // Read before write
        end
    end

endmodule

//--- test/arb_checker.sv
/* Handshake assertions for the memory arbiter, bound into every mem_arbiter
   instance and evaluated on each rising clock edge. */
`timescale 1ns/1ns

module arb_checker (
    input logic       clk,
    input logic       pon_rst_n_i,
    input logic [1:0] req_i,
    input logic [1:0] ack_i,
    input logic       ram_en_i
);

    int unsigned fails = 0;

    // Ack may linger one cycle after its req drops
    loader_ack_follows_req: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        ack_i[0] |-> (req_i[0] || $past(req_i[0])))
        else begin
            $error("loader ack without a pending request");
            fails++;
        end

    core_ack_follows_req: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        ack_i[1] |-> (req_i[1] || $past(req_i[1])))
        else begin
            $error("core ack without a pending request");
            fails++;
        end

    // Ack falls in the cycle after its req falls
    ack_drops_after_req: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        ((ack_i & ~req_i) != 2'b00) |=> (ack_i == 2'b00))
        else begin
            $error("ack still high one cycle after its request dropped");
            fails++;
        end

    // RAM access, then exactly one ack two cycles later
    ram_access_acked: assert property (@(posedge clk) disable iff (!pon_rst_n_i)
        $past(ram_en_i, 2) |-> $onehot(ack_i))
        else begin
            $error("RAM access not followed by a single ack two cycles later");
            fails++;
        end

endmodule

bind mem_arbiter arb_checker i_arb_checker (
    .clk         (clk),
    .pon_rst_n_i (pon_rst_n_i),
    .req_i       (req_i),
    .ack_i       (ack_o),
    .ram_en_i    (ram_en_o)
);

//--- test/cpu_tb.sv
/* Table-driven testbench for the CPU subsystem: loads programs over the host
   port, starts them, waits for HALT and checks r0 and the final pc. */
`timescale 1ns/1ns

module cpu_tb;

    localparam int NUM_FIXED   = 7;
    localparam int NUM_ENTRIES = 11;
    localparam int HS_TIMEOUT  = 64;                      // Cycles per handshake phase
    localparam int RUN_TIMEOUT = 1000;

    typedef struct packed {
        logic [3:0]                 nwords;
        cpu_pkg::word_t [0:7]       prog;                 // prog[0] sits at load_addr
        cpu_pkg::addr_t             load_addr;
        cpu_pkg::addr_t             start_addr;
        cpu_pkg::word_t             exp_r0;
        cpu_pkg::addr_t             exp_pc;
        logic                       overlap;              // Load next entry while running
    } prog_entry_t;

    logic               clk;
    logic               pon_rst_n;
    logic               cmd_req;
    cpu_pkg::host_cmd_t cmd;
    logic               cmd_ack;
    cpu_pkg::addr_t     pc;
    cpu_pkg::word_t     r0;
    logic               halt;
    logic               running;

    prog_entry_t progs [NUM_ENTRIES];
    int          value_errors;
    int          other_errors;
    bit          aborted;
    bit          skip_load;
    integer      seed;

    tb_clock_gen i_tb_clock_gen (
        .clk         (clk),
        .pon_rst_n_o (pon_rst_n)
    );

    cpu_subsystem i_cpu_subsystem (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n),
        .cmd_req_i   (cmd_req),
        .cmd_i       (cmd),
        .cmd_ack_o   (cmd_ack),
        .pc_o        (pc),
        .r0_o        (r0),
        .halt_o      (halt),
        .running_o   (running)
    );

    task automatic wait_cmd_ack(input logic level, input string phase);
        int n;
        n = 0;
        while (cmd_ack !== level && n < HS_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (cmd_ack !== level) begin
            $display("timeout: cmd_ack_o never went to %0b during %s", level, phase);
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    // Four-phase host command
    task automatic host_cmd(input logic kind, input cpu_pkg::addr_t addr,
                            input cpu_pkg::word_t data);
        if (aborted) return;
        @(negedge clk);
        if (cmd_ack !== 1'b0) begin
            $display("cmd_ack_o was still high when a new command began");
            other_errors++;
        end
        cmd.kind = kind;
        cmd.addr = addr;
        cmd.data = data;
        cmd_req  = 1'b1;
        wait_cmd_ack(1'b1, "request");
        if (aborted) return;
        @(negedge clk);                                   // Req held one more cycle
        if (cmd_ack !== 1'b1) begin
            $display("error: cmd_ack_o = %h while cmd_req_i still high, expected 1", cmd_ack);
            value_errors++;
        end
        cmd_req = 1'b0;
        wait_cmd_ack(1'b0, "release");
    endtask

    task automatic load_words(input int e);
        for (int w = 0; w < progs[e].nwords; w++) begin
            host_cmd(cpu_pkg::CMD_WRITE, progs[e].load_addr + 13'(w), progs[e].prog[w]);
        end
    endtask

    task automatic wait_halt(input int e);
        int n;
        n = 0;
        while (halt !== 1'b1 && n < RUN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (halt !== 1'b1) begin
            $display("timeout: program %0d never reached HALT", e);
            other_errors++;
            aborted = 1'b1;
        end
    endtask

    // Two random LDI bytes combined by ADD or SUB into R0
    task automatic build_random(input int e);
        logic [31:0]      r;
        cpu_pkg::word_t   a;
        cpu_pkg::word_t   b;
        cpu_pkg::opcode_t op;
        r  = $random(seed);
        a  = {8'h00, r[7:0]};
        b  = {8'h00, r[15:8]};
        op = r[16] ? cpu_pkg::OP_SUB : cpu_pkg::OP_ADD;
        progs[e].nwords     = 4'd4;
        progs[e].load_addr  = 13'h0400 + 13'(e * 16);
        progs[e].start_addr = progs[e].load_addr;
        progs[e].exp_r0     = r[16] ? a - b : a + b;      // Wraps modulo 2^16
        progs[e].exp_pc     = progs[e].load_addr + 13'd3;
        progs[e].overlap    = 1'b0;
        progs[e].prog = {{cpu_pkg::OP_LDI, 3'd1, 1'b0, r[7:0]},
                         {cpu_pkg::OP_LDI, 3'd2, 1'b0, r[15:8]},
                         {op, 3'd0, 3'd1, 3'd2, 3'd0},
                         {cpu_pkg::OP_HALT, 12'h000}, 64'h0};
    endtask

    task automatic run_entry(input int e);
        if (!skip_load) load_words(e);
        skip_load = 1'b0;
        host_cmd(cpu_pkg::CMD_START, progs[e].start_addr, '0);
        if (aborted) return;
        if (running !== 1'b1 || halt !== 1'b0) begin
            $display("error: running_o/halt_o = %h/%h after start of %0d, expected 1/0",
                     running, halt, e);
            value_errors++;
        end
        if (progs[e].overlap) begin
            host_cmd(cpu_pkg::CMD_START, 13'h0000, '0);  // Core is busy, start ignored
            if (running !== 1'b1) begin
                $display("error: running_o = %h after a start while running, expected 1",
                         running);
                value_errors++;
            end
            if (pc < progs[e].start_addr || pc > progs[e].exp_pc) begin
                $display("error: pc_o = %h after a start while running, expected %h to %h",
                         pc, progs[e].start_addr, progs[e].exp_pc);
                value_errors++;
            end
            load_words(e + 1);                            // Competes with fetches
            skip_load = 1'b1;
        end
        wait_halt(e);
        if (aborted) return;
        if (r0 !== progs[e].exp_r0) begin
            $display("error: r0_o = %h, expected %h (program %0d)", r0, progs[e].exp_r0, e);
            value_errors++;
        end
        if (pc !== progs[e].exp_pc) begin
            $display("error: pc_o = %h, expected %h (program %0d)", pc, progs[e].exp_pc, e);
            value_errors++;
        end
        if (running !== 1'b0) begin
            $display("error: running_o = %h after HALT, expected 0", running);
            value_errors++;
        end
    endtask

    initial begin
        int n;
        int asrt_fails;
        cmd_req      = 1'b0;
        cmd          = '0;
        value_errors = 0;
        other_errors = 0;
        aborted      = 1'b0;
        skip_load    = 1'b0;
        seed         = 32'h3ca0_6105;

        // LDI R0 then HALT
        progs[0] = '{nwords: 4'd2, load_addr: 13'h0000, start_addr: 13'h0000,
                     exp_r0: 16'h00a5, exp_pc: 13'h0001, overlap: 1'b0,
                     prog: {16'h30a5, 16'hf000, 96'h0}};
        progs[1] = '{nwords: 4'd4, load_addr: 13'h0010, start_addr: 13'h0010,
                     exp_r0: 16'h0104, exp_pc: 13'h0013, overlap: 1'b0,
                     prog: {16'h323c, 16'h34c8, 16'h1050, 16'hf000, 64'h0}};
        // 5 - 9 wraps
        progs[2] = '{nwords: 4'd4, load_addr: 13'h0020, start_addr: 13'h0020,
                     exp_r0: 16'hfffc, exp_pc: 13'h0023, overlap: 1'b0,
                     prog: {16'h3205, 16'h3409, 16'h2050, 16'hf000, 64'h0}};
        // JMP skips the LDI 0xee
        progs[3] = '{nwords: 4'd5, load_addr: 13'h0100, start_addr: 13'h0100,
                     exp_r0: 16'h0042, exp_pc: 13'h0104, overlap: 1'b0,
                     prog: {16'h3042, 16'h4104, 16'h30ee, 16'h0000, 16'hf000, 48'h0}};
        // Start one past the load address, then NOP and undefined opcodes
        progs[4] = '{nwords: 4'd7, load_addr: 13'h0200, start_addr: 13'h0201,
                     exp_r0: 16'h0011, exp_pc: 13'h0206, overlap: 1'b0,
                     prog: {16'h30ff, 16'h3011, 16'h0000, 16'h71ff, 16'he0a5, 16'h01ff,
                            16'hf000, 16'h0}};
        progs[5] = '{nwords: 4'd7, load_addr: 13'h0300, start_addr: 13'h0300,
                     exp_r0: 16'h0033, exp_pc: 13'h0306, overlap: 1'b1,
                     prog: {16'h3211, 16'h3422, 16'h0000, 16'h0000, 16'h0000, 16'h1050,
                            16'hf000, 16'h0}};
        // Written while entry 5 runs
        progs[6] = '{nwords: 4'd3, load_addr: 13'h1f00, start_addr: 13'h1f00,
                     exp_r0: 16'h0077, exp_pc: 13'h1f02, overlap: 1'b0,
                     prog: {16'h3077, 16'h0000, 16'hf000, 80'h0}};
        for (int e = NUM_FIXED; e < NUM_ENTRIES; e++) begin
            build_random(e);
        end

        n = 0;
        while (pon_rst_n !== 1'b1 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (pon_rst_n !== 1'b1) begin
            $display("timeout: power-on reset was never released");
            other_errors++;
            aborted = 1'b1;
        end
        if (cmd_ack !== 1'b0 || halt !== 1'b0 || running !== 1'b0) begin
            $display("error: cmd_ack_o/halt_o/running_o = %h/%h/%h after reset, expected 0/0/0",
                     cmd_ack, halt, running);
            value_errors++;
        end
        if (pc !== 13'h0000 || r0 !== 16'h0000) begin
            $display("error: pc_o/r0_o = %h/%h after reset, expected 0000/0000", pc, r0);
            value_errors++;
        end

        for (int e = 0; e < NUM_ENTRIES && !aborted; e++) begin
            run_entry(e);
        end

        asrt_fails = i_cpu_subsystem.i_mem_arbiter.i_arb_checker.fails;
        $display("%0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, asrt_fails);
        if (value_errors == 0 && other_errors == 0 && asrt_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/tb_clock_gen.sv
/* Testbench clock and power-on reset: 8 ns period, reset held low for 8 cycles. */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic pon_rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        pon_rst_n_o = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        pon_rst_n_o = 1'b1;                               // Released away from the active edge
    end

endmodule
